/* block_digest.f */
+incdir+design
design/block_digest_pkg.sv
design/mem_bus_if.sv
design/blockmem2rptr1w.sv
design/block_loader.sv
design/digest_engine.sv
design/result_port.sv
design/block_digest_top.sv
sim/block_digest_tb.sv

/* Makefile */
# Verilator build and run of the block digest testbench

BIN  := obj_dir/Vblock_digest_tb
SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) block_digest.f
	verilator --binary --assert --timescale 1ns/100ps -f block_digest.f \
	  --top-module block_digest_tb -o Vblock_digest_tb

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

/* sim/block_digest_tb.sv */
//////////////////////////////////////////////////////////////////////
// Block digest testbench: table of writes, reads and digests checked
// against a reference model of the block memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "block_digest_macros.svh"

module block_digest_tb;

  localparam int DONE_TIMEOUT = 300;
  localparam int READ_TIMEOUT = 8;

  typedef enum logic [2:0] {OP_WRITE, OP_CLEAR, OP_START, OP_READ, OP_BUSY} op_t;

  // One stimulus row with exp_word as the read word or the expected sum
  typedef struct {
    op_t                      op;
    block_digest_pkg::addr_t  addr;
    block_digest_pkg::word_t  data;
    block_digest_pkg::word_t  exp_word;
    block_digest_pkg::word_t  exp_xor;
    block_digest_pkg::count_t exp_count;
  } row_t;

  logic                     clk;
  logic                     rst_n;
  logic                     wr;
  block_digest_pkg::addr_t  wr_addr;
  block_digest_pkg::word_t  wr_data;
  logic                     clear;
  logic                     start;
  logic                     rd;
  block_digest_pkg::addr_t  rd_addr;
  logic                     busy;
  logic                     done;
  block_digest_pkg::word_t  rd_data;
  logic                     rd_valid;
  block_digest_pkg::word_t  sum_value;
  block_digest_pkg::word_t  xor_value;
  block_digest_pkg::count_t word_count;

  row_t                     stim_q[$];
  block_digest_pkg::word_t  model_mem [`BD_DEPTH];
  block_digest_pkg::count_t model_len;
  integer                   seed;

  block_digest_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .clear      (clear),
    .start      (start),
    .rd         (rd),
    .rd_addr    (rd_addr),
    .busy       (busy),
    .done       (done),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .sum_value  (sum_value),
    .xor_value  (xor_value),
    .word_count (word_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_word(input block_digest_pkg::word_t got,
                            input block_digest_pkg::word_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_count(input block_digest_pkg::count_t got,
                             input block_digest_pkg::count_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic timeout_stop(input string what, input int cycles);
    $display("Timeout at %0t ns: %s never came within %0d cycles", $time, what, cycles);
    $display("Test failures found");
    $fatal(1, "stopped on timeout");
  endtask

  // Reference model of the word array and the block length rule
  task automatic add_write(input block_digest_pkg::addr_t a, input block_digest_pkg::word_t d);
    row_t r;
    r = '{OP_WRITE, a, d, '0, '0, '0};
    model_mem[a] = d;
    if (block_digest_pkg::count_t'(a) + 9'd1 > model_len) begin
      model_len = block_digest_pkg::count_t'(a) + 9'd1;
    end
    stim_q.push_back(r);
  endtask

  task automatic add_clear();
    row_t r;
    r = '{OP_CLEAR, '0, '0, '0, '0, '0};
    model_len = '0;
    stim_q.push_back(r);
  endtask

  task automatic add_read(input block_digest_pkg::addr_t a);
    row_t r;
    r = '{OP_READ, a, '0, model_mem[a], '0, '0};
    stim_q.push_back(r);
  endtask

  // Sum modulo 2^32 and XOR over the current block
  task automatic add_digest(input op_t op, input block_digest_pkg::addr_t base);
    row_t r;
    int   i;
    r = '{op, base, '0, '0, '0, model_len};
    for (i = 0; i < int'(model_len); i++) begin
      r.exp_word = r.exp_word + model_mem[block_digest_pkg::addr_t'(i)];
      r.exp_xor  = r.exp_xor ^ model_mem[block_digest_pkg::addr_t'(i)];
    end
    stim_q.push_back(r);
  endtask

  task automatic do_write(input block_digest_pkg::addr_t a, input block_digest_pkg::word_t d);
    @(posedge clk);
    wr      <= 1'b1;
    wr_addr <= a;
    wr_data <= d;
    @(posedge clk);
    wr <= 1'b0;
  endtask

  task automatic do_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
  endtask

  // rd is sampled one edge after it is driven and rd_valid one edge later
  task automatic do_read(input block_digest_pkg::addr_t a, input block_digest_pkg::word_t exp);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk);
    rd      <= 1'b1;
    rd_addr <= a;
    while (!seen) begin
      @(posedge clk);
      rd <= 1'b0;
      cycles++;
      @(negedge clk);
      seen = rd_valid;
      if (!seen && cycles >= READ_TIMEOUT) begin
        timeout_stop("rd_valid", cycles);
      end
    end
    check_count(block_digest_pkg::count_t'(cycles), 9'd2, "read latency");
    check_word(rd_data, exp, "rd_data");
  endtask

  // Writes and reads go out on every busy cycle when traffic is set
  task automatic run_digest(input row_t row, input logic traffic);
    int                       cycles;
    logic                     seen;
    block_digest_pkg::count_t stray;
    block_digest_pkg::count_t busy_cycles;
    cycles      = 0;
    seen        = 1'b0;
    stray       = '0;
    busy_cycles = '0;
    @(posedge clk);
    start <= 1'b1;
    while (!seen) begin
      @(posedge clk);
      start <= 1'b0;
      cycles++;
      if (traffic) begin
        wr      <= 1'b1;
        wr_addr <= row.addr + block_digest_pkg::addr_t'(cycles);
        wr_data <= block_digest_pkg::word_t'($random(seed));
        rd      <= 1'b1;
        rd_addr <= row.addr;
      end
      @(negedge clk);
      seen = done;
      if (busy) begin
        busy_cycles = busy_cycles + 1'b1;
      end
      if (rd_valid) begin
        stray = stray + 1'b1;
      end
      if (!seen && cycles >= DONE_TIMEOUT) begin
        timeout_stop("done", cycles);
      end
    end
    // Results are captured on the done edge
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
    @(negedge clk);
    check_count(block_digest_pkg::count_t'(cycles), row.exp_count + 9'd2, "done latency");
    check_word(sum_value, row.exp_word, "sum_value");
    check_word(xor_value, row.exp_xor, "xor_value");
    check_count(word_count, row.exp_count, "word_count");
    repeat (3) begin
      if (rd_valid) begin
        stray = stray + 1'b1;
      end
      if (busy) begin
        busy_cycles = busy_cycles + 1'b1;
      end
      @(negedge clk);
    end
    check_count(stray, '0, "rd_valid pulses during busy");
    check_count(busy_cycles, row.exp_count + 9'd2, "busy cycles");
  endtask

  task automatic apply_row(input row_t row);
    case (row.op)
      OP_WRITE: do_write(row.addr, row.data);
      OP_CLEAR: do_clear();
      OP_READ:  do_read(row.addr, row.exp_word);
      OP_START: run_digest(row, 1'b0);
      default:  run_digest(row, 1'b1);
    endcase
  endtask

  initial begin
    int i;
    rst_n     = 1'b0;
    wr        = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    clear     = 1'b0;
    start     = 1'b0;
    rd        = 1'b0;
    rd_addr   = '0;
    model_len = '0;
    seed      = 32'hdf8b;

    // Short block followed by readback
    for (i = 0; i < 10; i++) begin
      add_write(block_digest_pkg::addr_t'(i), block_digest_pkg::word_t'($random(seed)));
    end
    add_digest(OP_START, '0);
    add_read(8'd0);
    add_read(8'd5);
    add_read(8'd9);
    // Full block run twice with the pointer wrapping
    for (i = 0; i < `BD_DEPTH; i++) begin
      add_write(block_digest_pkg::addr_t'(i), block_digest_pkg::word_t'($random(seed)));
    end
    add_digest(OP_START, '0);
    add_digest(OP_START, '0);
    add_read(8'd255);
    // After clear a single write at 3 keeps old words 0 to 2
    add_clear();
    add_write(8'd3, block_digest_pkg::word_t'($random(seed)));
    add_digest(OP_START, '0);
    // Stray traffic while busy must leave the memory untouched
    add_digest(OP_BUSY, 8'd0);
    for (i = 0; i < 7; i++) begin
      add_read(block_digest_pkg::addr_t'(i));
    end
    // Empty block
    add_clear();
    add_digest(OP_START, '0);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    foreach (stim_q[k]) begin
      apply_row(stim_q[k]);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* design/block_digest_top.sv */
//////////////////////////////////////////////////////////////////////
// Block digest unit: loader, block memory, engine and result port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module block_digest_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr,
  input  block_digest_pkg::addr_t  wr_addr,
  input  block_digest_pkg::word_t  wr_data,
  input  logic                     clear,
  input  logic                     start,
  input  logic                     rd,
  input  block_digest_pkg::addr_t  rd_addr,
  output logic                     busy,
  output logic                     done,
  output block_digest_pkg::word_t  rd_data,
  output logic                     rd_valid,
  output block_digest_pkg::word_t  sum_value,
  output block_digest_pkg::word_t  xor_value,
  output block_digest_pkg::count_t word_count
);

  // Pointer port
  logic                     ptr_rst;
  logic                     ptr_cs;
  block_digest_pkg::word_t  read_data1;

  // Engine to loader and result port
  block_digest_pkg::count_t block_len;
  block_digest_pkg::word_t  eng_sum;
  block_digest_pkg::word_t  eng_xor;
  block_digest_pkg::count_t eng_count;

  mem_bus_if bus_i ();

  block_loader loader_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .clear     (clear),
    .busy      (busy),
    .bus       (bus_i.writer),
    .block_len (block_len)
  );

  blockmem2rptr1w mem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus_i.mem),
    .ptr_rst    (ptr_rst),
    .ptr_cs     (ptr_cs),
    .read_data1 (read_data1)
  );

  digest_engine engine_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .block_len  (block_len),
    .ptr_rst    (ptr_rst),
    .ptr_cs     (ptr_cs),
    .read_data1 (read_data1),
    .busy       (busy),
    .done       (done),
    .sum_value  (eng_sum),
    .xor_value  (eng_xor),
    .word_count (eng_count)
  );

  result_port result_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .done       (done),
    .sum_in     (eng_sum),
    .xor_in     (eng_xor),
    .count_in   (eng_count),
    .busy       (busy),
    .rd         (rd),
    .rd_addr    (rd_addr),
    .bus        (bus_i.reader),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .sum_value  (sum_value),
    .xor_value  (xor_value),
    .word_count (word_count)
  );

endmodule

/* design/result_port.sv */
//////////////////////////////////////////////////////////////////////
// Result port: holds digest results and serves word readback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module result_port (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     done,
  input  block_digest_pkg::word_t  sum_in,
  input  block_digest_pkg::word_t  xor_in,
  input  block_digest_pkg::count_t count_in,
  input  logic                     busy,
  input  logic                     rd,
  input  block_digest_pkg::addr_t  rd_addr,
  mem_bus_if.reader                bus,
  output block_digest_pkg::word_t  rd_data,
  output logic                     rd_valid,
  output block_digest_pkg::word_t  sum_value,
  output block_digest_pkg::word_t  xor_value,
  output block_digest_pkg::count_t word_count
);

  logic                    rd_ok;
  logic                    rd_pend;
  block_digest_pkg::addr_t rd_addr_q;

  // No readback while the engine runs
  assign rd_ok = rd && !busy;

  // Address held so rd_data stays put while rd_valid is high
  always_ff @(posedge clk) begin
    if (rd_ok) begin
      rd_addr_q <= rd_addr;
    end
  end

  assign bus.read_addr0 = rd_addr_q;
  assign rd_data        = bus.read_data0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend    <= 1'b0;
      rd_valid   <= 1'b0;
      sum_value  <= '0;
      xor_value  <= '0;
      word_count <= '0;
    end else begin
      rd_pend  <= rd_ok;
      rd_valid <= rd_pend;
      if (done) begin
        sum_value  <= sum_in;
        xor_value  <= xor_in;
        word_count <= count_in;
      end
    end
  end

endmodule

/* design/digest_engine.sv */
//////////////////////////////////////////////////////////////////////
// Digest engine: streams the block and forms its sum and XOR
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module digest_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  block_digest_pkg::count_t block_len,
  output logic                     ptr_rst,
  output logic                     ptr_cs,
  input  block_digest_pkg::word_t  read_data1,
  output logic                     busy,
  output logic                     done,
  output block_digest_pkg::word_t  sum_value,
  output block_digest_pkg::word_t  xor_value,
  output block_digest_pkg::count_t word_count
);

  block_digest_pkg::engine_state_t state;
  block_digest_pkg::engine_state_t state_nxt;
  block_digest_pkg::count_t        remaining;
  block_digest_pkg::count_t        len_q;
  block_digest_pkg::word_t         sum_acc;
  block_digest_pkg::word_t         xor_acc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= block_digest_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      block_digest_pkg::IDLE: begin
        if (start) begin
          state_nxt = block_digest_pkg::CLEAR;
        end
      end
      block_digest_pkg::CLEAR: begin
        // Empty block goes straight to DONE
        state_nxt = (len_q == '0) ? block_digest_pkg::DONE : block_digest_pkg::SCAN;
      end
      block_digest_pkg::SCAN: begin
        if (remaining == block_digest_pkg::count_t'(1)) begin
          state_nxt = block_digest_pkg::DONE;
        end
      end
      default: begin
        state_nxt = block_digest_pkg::IDLE;
      end
    endcase
  end

  // Length latched on start, remaining words count down in SCAN
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      len_q     <= '0;
      remaining <= '0;
    end else if ((state == block_digest_pkg::IDLE) && start) begin
      len_q     <= block_len;
      remaining <= block_len;
    end else if (ptr_cs) begin
      remaining <= remaining - 1'b1;
    end
  end

  // Accumulators
  always_ff @(posedge clk) begin
    if (ptr_rst) begin
      sum_acc <= '0;
      xor_acc <= '0;
    end else if (ptr_cs) begin
      sum_acc <= sum_acc + read_data1;
      xor_acc <= xor_acc ^ read_data1;
    end
  end

  assign ptr_rst    = (state == block_digest_pkg::CLEAR);
  assign ptr_cs     = (state == block_digest_pkg::SCAN);
  assign busy       = (state != block_digest_pkg::IDLE);
  assign done       = (state == block_digest_pkg::DONE);
  assign sum_value  = sum_acc;
  assign xor_value  = xor_acc;
  assign word_count = len_q;

endmodule

/* design/block_loader.sv */
//////////////////////////////////////////////////////////////////////
// Block loader: gates host writes and tracks the block length
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module block_loader (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr,
  input  block_digest_pkg::addr_t  wr_addr,
  input  block_digest_pkg::word_t  wr_data,
  input  logic                     clear,
  input  logic                     busy,
  mem_bus_if.writer                bus,
  output block_digest_pkg::count_t block_len
);

  logic                     wr_ok;
  block_digest_pkg::count_t wr_end;

  // Writes are dropped while the engine runs
  assign wr_ok = wr && !busy;

  // One past the written address
  assign wr_end = block_digest_pkg::count_t'(wr_addr) + 1'b1;

  assign bus.wr         = wr_ok;
  assign bus.write_addr = wr_addr;
  assign bus.write_data = wr_data;

  // Length grows to the highest written address plus one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      block_len <= '0;
    end else if (clear) begin
      // A write in the same cycle starts the new block
      block_len <= wr_ok ? wr_end : '0;
    end else if (wr_ok && (wr_end > block_len)) begin
      block_len <= wr_end;
    end
  end

endmodule

/* design/blockmem2rptr1w.sv */
//////////////////////////////////////////////////////////////////////
// Block memory with one write port, a registered read port and a
// streaming read port on an auto-incrementing pointer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "block_digest_macros.svh"

module blockmem2rptr1w (
  input  logic                    clk,
  input  logic                    rst_n,
  mem_bus_if.mem                  bus,
  input  logic                    ptr_rst,
  input  logic                    ptr_cs,
  output block_digest_pkg::word_t read_data1
);

  block_digest_pkg::word_t ram [`BD_DEPTH];
  block_digest_pkg::addr_t ptr;

  // Write port and registered read port, read before write
  always_ff @(posedge clk) begin
    if (bus.wr) begin
      ram[bus.write_addr] <= bus.write_data;
    end
    bus.read_data0 <= ram[bus.read_addr0];
  end

  // Stream pointer, increment has priority over clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (ptr_cs) begin
      ptr <= ptr + 1'b1;
    end else if (ptr_rst) begin
      ptr <= '0;
    end
  end

  // Streaming read is combinational on the pointer
  assign read_data1 = ram[ptr];

  // Pointer steps by one below the top address
  ap_ptr_inc: assert property (@(posedge clk) disable iff (!rst_n)
    (ptr_cs && (ptr != '1)) |=> (ptr == $past(ptr) + 8'd1));

  // Wrap from 255 back to 0
  ap_ptr_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (ptr_cs && (ptr == '1)) |=> (ptr == '0));

  // Clear only when not incrementing
  ap_ptr_clr: assert property (@(posedge clk) disable iff (!rst_n)
    (ptr_rst && !ptr_cs) |=> (ptr == '0));

  // Idle pointer holds
  ap_ptr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!ptr_rst && !ptr_cs) |=> $stable(ptr));

  // A written word is visible one cycle later
  ap_wr_visible: assert property (@(posedge clk)
    bus.wr |=> (ram[$past(bus.write_addr)] == $past(bus.write_data)));

  // Registered read returns last cycle's word at the read address
  ap_rd0: assert property (@(posedge clk) disable iff (!rst_n)
    bus.read_data0 === $past(ram[bus.read_addr0]));

  // Pointer port sees a fresh write to a parked pointer on the next cycle
  ap_rd1_fresh: assert property (@(posedge clk) disable iff (!rst_n)
    (bus.wr && (bus.write_addr == ptr) && !ptr_cs && !ptr_rst)
    |=> (read_data1 == $past(bus.write_data)));

endmodule

/* design/mem_bus_if.sv */
//////////////////////////////////////////////////////////////////////
// Host side memory bus: write port and registered read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface mem_bus_if;

  // Write port
  logic                    wr;
  block_digest_pkg::addr_t write_addr;
  block_digest_pkg::word_t write_data;

  // Registered read port
  block_digest_pkg::addr_t read_addr0;
  block_digest_pkg::word_t read_data0;

  // Loader side
  modport writer (
    output wr, write_addr, write_data
  );

  // Readback side
  modport reader (
    output read_addr0,
    input  read_data0
  );

  // Memory side
  modport mem (
    input  wr, write_addr, write_data, read_addr0,
    output read_data0
  );

endinterface

/* design/block_digest_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Block digest types: words, addresses, counts and engine states
//////////////////////////////////////////////////////////////////////

`include "block_digest_macros.svh"

package block_digest_pkg;

  // One memory word
  typedef logic [`BD_WORD_W-1:0] word_t;

  // Memory address
  typedef logic [`BD_ADDR_W-1:0] addr_t;

  // Block length, one bit wider so a full block of 256 fits
  typedef logic [`BD_ADDR_W:0] count_t;

  // Digest engine FSM
  typedef enum logic [1:0] {
    IDLE,
    CLEAR,
    SCAN,
    DONE
  } engine_state_t;

endpackage

/* design/block_digest_macros.svh */
//////////////////////////////////////////////////////////////////////
// Block digest widths, shared by the package and the RTL
//////////////////////////////////////////////////////////////////////

`ifndef BLOCK_DIGEST_MACROS_SVH
`define BLOCK_DIGEST_MACROS_SVH

// Memory address width
`define BD_ADDR_W 8

// Data word width
`define BD_WORD_W 32

// Number of words in the block memory
`define BD_DEPTH 256

`endif
